// ==== rtl/xfer_pkg.sv ====
`default_nettype none

package xfer_pkg;

    // ==========================================================
    // Widths
    // ==========================================================
    localparam int DATA_W = 128;
    localparam int ADDR_W = 32;
    localparam int CNT_W  = 16;

    // Burst sizing, FIFO holds exactly one burst
    localparam int BURST_LEN  = 8;
    localparam int FIFO_DEPTH = BURST_LEN;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);

    // Command word field positions
    localparam int CMD_DIR_BIT  = 0;
    localparam int CMD_ADDR_LSB = 1;
    localparam int CMD_CNT_LSB  = 33;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // Top sequencer states
    typedef enum logic [1:0] {
        C_IDLE,
        C_READ,
        C_WRITE,
        C_DONE
    } ctrl_state_t;

    // Engine states, same shape for read and write side
    typedef enum logic [1:0] {
        E_IDLE,
        E_CMD,
        E_DATA,
        E_FNH
    } eng_state_t;

    // Pack a command word, unused upper bits stay zero
    function automatic word_t make_cmd(logic dir, addr_t addr, cnt_t cnt);
        word_t w;
        w = '0;
        w[CMD_DIR_BIT] = dir;
        w[CMD_ADDR_LSB +: $bits(addr_t)] = addr;
        w[CMD_CNT_LSB +: $bits(cnt_t)] = cnt;
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/bus_read_engine.sv ====
`default_nettype none

module bus_read_engine (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  go,
    input  wire xfer_pkg::addr_t burst_addr,
    input  wire xfer_pkg::cnt_t  burst_len,
    input  wire xfer_pkg::word_t bus_dat_in,
    input  wire                  bus_vld_in,
    input  wire                  bus_last_in,
    input  wire                  bus_rdy_in,
    input  wire                  fifo_full,
    output xfer_pkg::word_t      cmd_dat,
    output logic                 cmd_vld,
    output logic                 rdy_out,
    output logic                 push,
    output xfer_pkg::word_t      push_dat,
    output logic                 fin
);
    import xfer_pkg::*;

    eng_state_t state;
    eng_state_t state_nxt;
    cnt_t       word_cnt;
    logic       cmd_hs;
    logic       last_word;

    // ==========================================================
    // Command and data handshakes
    // ==========================================================
    // Read command, dir bit low
    assign cmd_dat = make_cmd(1'b0, burst_addr, burst_len);
    assign cmd_vld = (state == E_CMD);
    // Memory owns ready during command phase
    assign cmd_hs  = cmd_vld && bus_rdy_in;

    // Back-pressure memory while FIFO has no room
    assign rdy_out   = (state == E_DATA) && !fifo_full;
    assign push      = rdy_out && bus_vld_in;
    assign push_dat  = bus_dat_in;
    assign last_word = (word_cnt == burst_len - cnt_t'(1));
    assign fin       = (state == E_FNH);

    // ==========================================================
    // FSM
    // ==========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            E_IDLE:
                if (go)
                    state_nxt = E_CMD;
            E_CMD:
                if (cmd_hs)
                    state_nxt = E_DATA;
            E_DATA:
                // Leave on final counted word
                if (push && last_word)
                    state_nxt = E_FNH;
            E_FNH:
                state_nxt = E_IDLE;
            default:
                state_nxt = E_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= E_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Words accepted in this burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (state == E_IDLE) begin
            word_cnt <= '0;
        end else if (push) begin
            word_cnt <= word_cnt + cnt_t'(1);
        end
    end

    // Never accepts more words than the burst holds
    a_push_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (word_cnt < burst_len));

    // Memory last flag agrees with local count
    a_last_align: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (bus_last_in == last_word));

endmodule

`default_nettype wire

// ==== rtl/burst_fifo.sv ====
`default_nettype none

module burst_fifo (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  push,
    input  wire xfer_pkg::word_t push_dat,
    input  wire                  pop,
    output xfer_pkg::word_t      head_dat,
    output logic                 full,
    output logic                 empty
);
    import xfer_pkg::*;

    word_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from empty
    logic [PTR_W:0]   count;

    // ==========================================================
    // Storage
    // ==========================================================
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_dat;
        end
    end

    // Head word visible the cycle after its push
    assign head_dat = mem[rd_ptr];

    // ==========================================================
    // Pointers and occupancy
    // ==========================================================
    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + (PTR_W + 1)'(1);
                2'b01:   count <= count - (PTR_W + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/bus_write_engine.sv ====
`default_nettype none

module bus_write_engine (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  go,
    input  wire xfer_pkg::addr_t burst_addr,
    input  wire xfer_pkg::cnt_t  burst_len,
    input  wire                  bus_rdy_in,
    input  wire xfer_pkg::word_t head_dat,
    input  wire                  empty,
    output xfer_pkg::word_t      dat_out,
    output logic                 vld_out,
    output logic                 last_out,
    output logic                 pop,
    output logic                 fin
);
    import xfer_pkg::*;

    eng_state_t state;
    eng_state_t state_nxt;
    cnt_t       word_cnt;
    word_t      cmd_word;
    logic       hs;
    logic       last_word;

    // ==========================================================
    // Bus outputs
    // ==========================================================
    // Write command, dir bit high
    assign cmd_word = make_cmd(1'b1, burst_addr, burst_len);

    // Command first, then FIFO head whenever one is waiting
    assign vld_out   = (state == E_CMD) || ((state == E_DATA) && !empty);
    assign dat_out   = (state == E_DATA) ? head_dat : cmd_word;
    assign last_word = (word_cnt == burst_len - cnt_t'(1));
    assign last_out  = (state == E_DATA) && !empty && last_word;

    // Memory holds ready low to stall, nothing lost
    assign hs  = vld_out && bus_rdy_in;
    assign pop = (state == E_DATA) && hs;
    assign fin = (state == E_FNH);

    // ==========================================================
    // FSM
    // ==========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            E_IDLE:
                if (go)
                    state_nxt = E_CMD;
            E_CMD:
                if (hs)
                    state_nxt = E_DATA;
            E_DATA:
                if (pop && last_word)
                    state_nxt = E_FNH;
            E_FNH:
                state_nxt = E_IDLE;
            default:
                state_nxt = E_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= E_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Data words sent in this burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (state == E_IDLE) begin
            word_cnt <= '0;
        end else if (pop) begin
            word_cnt <= word_cnt + cnt_t'(1);
        end
    end

    // Never sends more data words than the burst holds
    a_pop_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (word_cnt < burst_len));

endmodule

`default_nettype wire

// ==== rtl/copy_ctrl.sv ====
`default_nettype none

module copy_ctrl (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire xfer_pkg::addr_t src_base,
    input  wire xfer_pkg::addr_t dst_base,
    input  wire xfer_pkg::cnt_t  word_count,
    input  wire xfer_pkg::word_t rd_cmd_dat,
    input  wire                  rd_cmd_vld,
    input  wire                  rd_rdy_out,
    input  wire                  rd_fin,
    input  wire xfer_pkg::word_t wr_dat_out,
    input  wire                  wr_vld_out,
    input  wire                  wr_last_out,
    input  wire                  wr_fin,
    output logic                 busy,
    output logic                 done,
    output logic                 bus_oe,
    output logic                 rd_go,
    output logic                 wr_go,
    output xfer_pkg::addr_t      burst_addr_rd,
    output xfer_pkg::addr_t      burst_addr_wr,
    output xfer_pkg::cnt_t       burst_len,
    inout  wire xfer_pkg::word_t bus_dat,
    inout  wire                  bus_vld,
    inout  wire                  bus_last,
    inout  wire                  bus_rdy,
    output xfer_pkg::word_t      bus_dat_in,
    output logic                 bus_vld_in,
    output logic                 bus_last_in,
    output logic                 bus_rdy_in
);
    import xfer_pkg::*;

    ctrl_state_t state;
    addr_t       src_addr;
    addr_t       dst_addr;
    cnt_t        remain;
    cnt_t        len_cur;
    cnt_t        remain_nxt;
    logic        start_ok;
    logic        last_burst;
    // Read go for bursts after the first, once counters have moved
    logic        go_q;
    // Memory owns the bus during read data
    logic        rd_data;
    word_t       out_dat;
    logic        out_vld;
    logic        out_last;

    function automatic cnt_t clip_len(cnt_t n);
        cnt_t lim;
        lim = cnt_t'(BURST_LEN);
        return (n > lim) ? lim : n;
    endfunction

    // ==========================================================
    // Burst sequencing
    // ==========================================================
    // Zero counts and starts while busy fall through here
    assign start_ok   = (state == C_IDLE) && start && (word_count != '0);
    assign remain_nxt = remain - len_cur;
    assign last_burst = (remain_nxt == '0);

    assign rd_go = start_ok || go_q;
    assign wr_go = (state == C_READ) && rd_fin;

    // First burst comes straight from the start inputs
    assign burst_addr_rd = (state == C_IDLE) ? src_base : src_addr;
    assign burst_addr_wr = dst_addr;
    assign burst_len     = (state == C_IDLE) ? clip_len(word_count) : len_cur;

    assign busy = (state != C_IDLE);
    assign done = (state == C_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= C_IDLE;
            go_q    <= 1'b0;
            rd_data <= 1'b0;
        end else begin
            go_q <= 1'b0;
            case (state)
                C_IDLE:
                    if (start_ok)
                        state <= C_READ;
                C_READ:
                    if (rd_fin)
                        state <= C_WRITE;
                C_WRITE:
                    if (wr_fin && last_burst) begin
                        state <= C_DONE;
                    end else if (wr_fin) begin
                        state <= C_READ;
                        go_q  <= 1'b1;
                    end
                default:
                    state <= C_IDLE;
            endcase
            // Turn the bus around after the read command handshake
            if (rd_fin) begin
                rd_data <= 1'b0;
            end else if ((state == C_READ) && rd_cmd_vld && bus_rdy) begin
                rd_data <= 1'b1;
            end
        end
    end

    // Running addresses and count
    always_ff @(posedge clk) begin
        if (start_ok) begin
            src_addr <= src_base;
            dst_addr <= dst_base;
            remain   <= word_count;
            len_cur  <= clip_len(word_count);
        end else if ((state == C_WRITE) && wr_fin) begin
            src_addr <= src_addr + addr_t'(len_cur);
            dst_addr <= dst_addr + addr_t'(len_cur);
            remain   <= remain_nxt;
            len_cur  <= clip_len(remain_nxt);
        end
    end

    // ==========================================================
    // Tristate pins
    // ==========================================================
    // Read engine owns the bus only for its command
    assign out_dat  = (state == C_READ) ? rd_cmd_dat : wr_dat_out;
    assign out_vld  = (state == C_READ) ? rd_cmd_vld : wr_vld_out;
    assign out_last = (state == C_WRITE) && wr_last_out;

    assign bus_oe   = !rd_data;
    assign bus_dat  = bus_oe ? out_dat : 'z;
    assign bus_vld  = bus_oe ? out_vld : 1'bz;
    assign bus_last = bus_oe ? out_last : 1'bz;
    assign bus_rdy  = bus_oe ? 1'bz : rd_rdy_out;

    // Pin values back to both engines
    assign bus_dat_in  = bus_dat;
    assign bus_vld_in  = bus_vld;
    assign bus_last_in = bus_last;
    assign bus_rdy_in  = bus_rdy;

    // Engines never start in the same cycle
    a_go_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_go && wr_go));

endmodule

`default_nettype wire

// ==== rtl/copy_top.sv ====
`default_nettype none

module copy_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire xfer_pkg::addr_t src_base,
    input  wire xfer_pkg::addr_t dst_base,
    input  wire xfer_pkg::cnt_t  word_count,
    output wire                  busy,
    output wire                  done,
    output wire                  bus_oe,
    inout  wire xfer_pkg::word_t bus_dat,
    inout  wire                  bus_vld,
    inout  wire                  bus_last,
    inout  wire                  bus_rdy
);
    import xfer_pkg::*;

    // Read engine side
    wire word_t rd_cmd_dat;
    wire        rd_cmd_vld;
    wire        rd_rdy_out;
    wire        rd_fin;
    wire        rd_go;
    wire addr_t burst_addr_rd;
    // Write engine side
    wire word_t wr_dat_out;
    wire        wr_vld_out;
    wire        wr_last_out;
    wire        wr_fin;
    wire        wr_go;
    wire addr_t burst_addr_wr;
    wire cnt_t  burst_len;
    // Bus values seen by the engines
    wire word_t bus_dat_in;
    wire        bus_vld_in;
    wire        bus_last_in;
    wire        bus_rdy_in;
    // FIFO
    wire        push;
    wire word_t push_dat;
    wire        pop;
    wire word_t head_dat;
    wire        full;
    wire        empty;

    copy_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .src_base      (src_base),
        .dst_base      (dst_base),
        .word_count    (word_count),
        .rd_cmd_dat    (rd_cmd_dat),
        .rd_cmd_vld    (rd_cmd_vld),
        .rd_rdy_out    (rd_rdy_out),
        .rd_fin        (rd_fin),
        .wr_dat_out    (wr_dat_out),
        .wr_vld_out    (wr_vld_out),
        .wr_last_out   (wr_last_out),
        .wr_fin        (wr_fin),
        .busy          (busy),
        .done          (done),
        .bus_oe        (bus_oe),
        .rd_go         (rd_go),
        .wr_go         (wr_go),
        .burst_addr_rd (burst_addr_rd),
        .burst_addr_wr (burst_addr_wr),
        .burst_len     (burst_len),
        .bus_dat       (bus_dat),
        .bus_vld       (bus_vld),
        .bus_last      (bus_last),
        .bus_rdy       (bus_rdy),
        .bus_dat_in    (bus_dat_in),
        .bus_vld_in    (bus_vld_in),
        .bus_last_in   (bus_last_in),
        .bus_rdy_in    (bus_rdy_in)
    );

    bus_read_engine u_rd (
        .clk         (clk),
        .rst_n       (rst_n),
        .go          (rd_go),
        .burst_addr  (burst_addr_rd),
        .burst_len   (burst_len),
        .bus_dat_in  (bus_dat_in),
        .bus_vld_in  (bus_vld_in),
        .bus_last_in (bus_last_in),
        .bus_rdy_in  (bus_rdy_in),
        .fifo_full   (full),
        .cmd_dat     (rd_cmd_dat),
        .cmd_vld     (rd_cmd_vld),
        .rdy_out     (rd_rdy_out),
        .push        (push),
        .push_dat    (push_dat),
        .fin         (rd_fin)
    );

    burst_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_dat (push_dat),
        .pop      (pop),
        .head_dat (head_dat),
        .full     (full),
        .empty    (empty)
    );

    bus_write_engine u_wr (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (wr_go),
        .burst_addr (burst_addr_wr),
        .burst_len  (burst_len),
        .bus_rdy_in (bus_rdy_in),
        .head_dat   (head_dat),
        .empty      (empty),
        .dat_out    (wr_dat_out),
        .vld_out    (wr_vld_out),
        .last_out   (wr_last_out),
        .pop        (pop),
        .fin        (wr_fin)
    );

endmodule

`default_nettype wire

// ==== bench/mem_model.sv ====
`default_nettype none

module mem_model (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  bus_oe,
    input  wire                  stall_en,
    input  wire                  fill,
    input  wire                  log_clr,
    inout  wire xfer_pkg::word_t bus_dat,
    inout  wire                  bus_vld,
    inout  wire                  bus_last,
    inout  wire                  bus_rdy
);
    timeunit 1ns;
    timeprecision 100ps;
    import xfer_pkg::*;

    localparam int         MEM_WORDS = 1024;
    localparam int         LOG_MAX   = 16;
    localparam logic [1:0] PH_IDLE   = 2'd0;
    localparam logic [1:0] PH_READ   = 2'd1;
    localparam logic [1:0] PH_WRITE  = 2'd2;

    word_t       mem [MEM_WORDS];
    word_t       log_cmd [LOG_MAX];
    int          log_n;
    logic        last_seen;
    int          last_err;
    logic [1:0]  phase;
    addr_t       m_addr;
    cnt_t        m_cnt;
    cnt_t        m_idx;
    logic [31:0] stall_state;
    logic [31:0] fill_state = 32'h38e6;
    logic        stall;
    logic        mem_vld;
    logic        mem_rdy;
    logic        m_final;
    logic [9:0]  m_ptr;
    logic        wr_hs;
    logic        rd_hs;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // ==========================================================
    // Bus side
    // ==========================================================
    assign stall   = stall_en && stall_state[0];
    assign m_final = (m_idx == m_cnt - cnt_t'(1));
    assign m_ptr   = m_addr[9:0] + m_idx[9:0];
    assign mem_vld = (phase == PH_READ) && !stall;
    assign mem_rdy = !stall;

    // Memory drives ready while engine owns the bus, the rest otherwise
    assign bus_rdy  = bus_oe ? mem_rdy : 1'bz;
    assign bus_vld  = bus_oe ? 1'bz : mem_vld;
    assign bus_dat  = bus_oe ? 'z : mem[m_ptr];
    assign bus_last = bus_oe ? 1'bz : (mem_vld && m_final);

    assign wr_hs = bus_oe && bus_vld && mem_rdy;
    assign rd_hs = !bus_oe && mem_vld && bus_rdy;

    // Command decode, burst tracking and command log
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= PH_IDLE;
            m_addr      <= '0;
            m_cnt       <= '0;
            m_idx       <= '0;
            log_n       <= 0;
            last_seen   <= 1'b0;
            last_err    <= 0;
            stall_state <= 32'h38e6;
        end else begin
            stall_state <= lfsr_step(stall_state);
            if (log_clr) begin
                log_n     <= 0;
                last_seen <= 1'b0;
                last_err  <= 0;
            end
            if (wr_hs && (phase == PH_IDLE)) begin
                // First word of a command phase
                if (log_n < LOG_MAX)
                    log_cmd[log_n[3:0]] <= bus_dat;
                log_n  <= log_n + 1;
                m_addr <= bus_dat[CMD_ADDR_LSB +: ADDR_W];
                m_cnt  <= bus_dat[CMD_CNT_LSB +: CNT_W];
                m_idx  <= '0;
                phase  <= bus_dat[CMD_DIR_BIT] ? PH_WRITE : PH_READ;
            end else if (wr_hs && (phase == PH_WRITE)) begin
                if (bus_last)
                    last_seen <= 1'b1;
                // Last must mark exactly the final word
                if (bus_last != m_final)
                    last_err <= last_err + 1;
                m_idx <= m_idx + cnt_t'(1);
                if (m_final)
                    phase <= PH_IDLE;
            end else if (rd_hs) begin
                m_idx <= m_idx + cnt_t'(1);
                if (m_final)
                    phase <= PH_IDLE;
            end
        end
    end

    // ==========================================================
    // Storage, LFSR fill or bus writes
    // ==========================================================
    always @(posedge clk) begin
        word_t w;
        if (fill) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                for (int b = 0; b < DATA_W; b++) begin
                    fill_state = lfsr_step(fill_state);
                    w[b] = fill_state[0];
                end
                mem[i] <= w;
            end
        end else if (wr_hs && (phase == PH_WRITE)) begin
            mem[m_ptr] <= bus_dat;
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_copy.sv ====
`default_nettype none

module tb_copy;
    timeunit 1ns;
    timeprecision 100ps;
    import xfer_pkg::*;

    // Whole run is a few hundred cycles, generous margin
    localparam int TIMEOUT = 4000;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  start;
    addr_t src_base;
    addr_t dst_base;
    cnt_t  word_count;
    logic  stall_en;
    logic  fill;
    logic  log_clr;
    wire   busy;
    wire   done;
    wire   bus_oe;
    wire word_t bus_dat;
    wire   bus_vld;
    wire   bus_last;
    wire   bus_rdy;

    word_t img [1024];
    int    err_word;
    int    err_addr;
    int    err_flag;
    int    err_count;
    int    cycles = 0;

    copy_top u_dut (
        .clk(clk), .rst_n(rst_n), .start(start), .src_base(src_base),
        .dst_base(dst_base), .word_count(word_count), .busy(busy),
        .done(done), .bus_oe(bus_oe), .bus_dat(bus_dat), .bus_vld(bus_vld),
        .bus_last(bus_last), .bus_rdy(bus_rdy)
    );

    mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .bus_oe(bus_oe), .stall_en(stall_en),
        .fill(fill), .log_clr(log_clr), .bus_dat(bus_dat), .bus_vld(bus_vld),
        .bus_last(bus_last), .bus_rdy(bus_rdy)
    );

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout waiting for done");
            $display("Test failed");
            $finish;
        end
    end

    // ==========================================================
    // Compare tasks
    // ==========================================================
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            err_word++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            err_addr++;
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input bit act);
        if (exp !== act) begin
            $display("mismatch %s expected %0b actual %0b", name, exp, act);
            err_flag++;
        end
    endtask

    task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
        if (exp !== act) begin
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    // ==========================================================
    // Helpers
    // ==========================================================
    function automatic int mem_index(addr_t a);
        return int'(a[9:0]);
    endfunction

    // New LFSR image, clear command log, save source copy
    task automatic prepare_mem(input logic stall);
        @(posedge clk);
        #1;
        stall_en = stall;
        fill     = 1'b1;
        log_clr  = 1'b1;
        @(posedge clk);
        #1;
        fill    = 1'b0;
        log_clr = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 1024; i++)
            img[i] = u_mem.mem[i];
    endtask

    task automatic pulse_start(input addr_t src, input addr_t dst, input cnt_t cnt);
        @(posedge clk);
        #1;
        start      = 1'b1;
        src_base   = src;
        dst_base   = dst;
        word_count = cnt;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done;
        do
            @(negedge clk);
        while (!done);
    endtask

    // Destination against source image, plus both neighbours
    task automatic check_copy(input string name, input addr_t src, input addr_t dst,
                              input cnt_t cnt);
        for (int i = 0; i < int'(cnt); i++)
            check_word(name, img[mem_index(src + i)], u_mem.mem[mem_index(dst + i)]);
        check_word(name, img[mem_index(dst - 1)], u_mem.mem[mem_index(dst - 1)]);
        check_word(name, img[mem_index(dst + addr_t'(cnt))],
                   u_mem.mem[mem_index(dst + addr_t'(cnt))]);
    endtask

    // Fields per command rule, bit 0 dir, 32..1 addr, 48..33 count
    task automatic check_cmd(input string name, input int idx, input bit dir,
                             input addr_t addr, input cnt_t cnt);
        word_t cmd;
        word_t exp;
        cmd = u_mem.log_cmd[idx];
        exp = '0;
        exp[0] = dir;
        exp[32:1] = addr;
        exp[48:33] = cnt;
        check_flag(name, dir, cmd[0]);
        check_addr(name, addr, cmd[32:1]);
        check_count(name, cnt, cmd[48:33]);
        check_word(name, exp, cmd);
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic test_single_burst;
        prepare_mem(1'b0);
        pulse_start(32'd16, 32'd512, 16'd8);
        wait_done();
        check_count("single_burst", 16'd2, cnt_t'(u_mem.log_n));
        check_cmd("single_burst", 0, 1'b0, 32'd16, 16'd8);
        check_cmd("single_burst", 1, 1'b1, 32'd512, 16'd8);
        check_copy("single_burst", 32'd16, 32'd512, 16'd8);
    endtask

    task automatic test_one_word;
        prepare_mem(1'b0);
        pulse_start(32'd100, 32'd700, 16'd1);
        wait_done();
        check_flag("one_word", 1'b1, u_mem.last_seen);
        check_count("one_word", 16'd0, cnt_t'(u_mem.last_err));
        check_copy("one_word", 32'd100, 32'd700, 16'd1);
    endtask

    // 19 words as bursts of 8, 8, 3
    task automatic test_three_bursts(input string name, input logic stall);
        cnt_t len;
        prepare_mem(stall);
        pulse_start(32'd200, 32'd600, 16'd19);
        wait_done();
        check_count(name, 16'd6, cnt_t'(u_mem.log_n));
        for (int b = 0; b < 3; b++) begin
            len = (b < 2) ? 16'd8 : 16'd3;
            check_cmd(name, 2 * b, 1'b0, addr_t'(200 + 8 * b), len);
            check_cmd(name, 2 * b + 1, 1'b1, addr_t'(600 + 8 * b), len);
        end
        check_count(name, 16'd0, cnt_t'(u_mem.last_err));
        check_copy(name, 32'd200, 32'd600, 16'd19);
    endtask

    task automatic test_flags;
        prepare_mem(1'b0);
        pulse_start(32'd300, 32'd800, 16'd4);
        @(negedge clk);
        check_flag("flags_busy_rise", 1'b1, busy);
        // Second start while busy, must be ignored
        pulse_start(32'd40, 32'd900, 16'd8);
        wait_done();
        check_flag("flags_busy_at_done", 1'b1, busy);
        @(negedge clk);
        check_flag("flags_busy_fall", 1'b0, busy);
        check_flag("flags_done_pulse", 1'b0, done);
        check_count("flags_restart", 16'd2, cnt_t'(u_mem.log_n));
        check_copy("flags_restart", 32'd300, 32'd800, 16'd4);

        // Zero count
        prepare_mem(1'b0);
        pulse_start(32'd10, 32'd20, 16'd0);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (done) begin
                $display("done pulsed for a zero word count");
                err_flag++;
            end
        end
        check_flag("flags_zero_busy", 1'b0, busy);
        check_count("flags_zero_cmds", 16'd0, cnt_t'(u_mem.log_n));
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        int total;
        rst_n      = 1'b0;
        start      = 1'b0;
        src_base   = '0;
        dst_base   = '0;
        word_count = '0;
        stall_en   = 1'b0;
        fill       = 1'b0;
        log_clr    = 1'b0;
        err_word   = 0;
        err_addr   = 0;
        err_flag   = 0;
        err_count  = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("reset_bus_oe", 1'b1, bus_oe);
        check_flag("reset_busy", 1'b0, busy);
        check_flag("reset_done", 1'b0, done);

        test_single_burst();
        test_one_word();
        test_three_bursts("three_bursts", 1'b0);
        test_three_bursts("three_bursts_stall", 1'b1);
        test_flags();

        total = err_word + err_addr + err_flag + err_count;
        $display("errors word=%0d addr=%0d flag=%0d count=%0d",
                 err_word, err_addr, err_flag, err_count);
        if (total == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/xfer_pkg.sv
rtl/bus_read_engine.sv
rtl/burst_fifo.sv
rtl/bus_write_engine.sv
rtl/copy_ctrl.sv
rtl/copy_top.sv
bench/mem_model.sv
bench/tb_copy.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_copy
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	grep -q '^Test passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
